// ==== hdl/core_cfg.svh ====
// Build constants for the radio control core
//   field widths of the settings bus, time and readback port
//   settings-bus register map and register offsets
//   compatibility number and reset values
//   readback word numbers
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

`define SET_ADDR_W      8
`define SET_DATA_W      32
`define CTRL_W          8
`define LED_W           8
`define VITA_TIME_W     64
`define RB_ADDR_W       4
`define RB_WORD_W       32

// Misc register block
`define SR_MISC         0
`define MISC_OFS_CLK    0
`define MISC_OFS_SER    1
`define MISC_OFS_ADC    2
`define MISC_OFS_LED_SW 3
`define MISC_OFS_PHY    4
`define MISC_OFS_LED_SRC 6

// Pin bits used from each control byte
`define CLK_CTRL_BITS   5
`define SER_CTRL_BITS   4
`define ADC_CTRL_BITS   4

// Time registers, high word first
`define SR_TIME64       10
`define TIME_OFS_HI     0
`define TIME_OFS_LO     1

// Bump when the register map changes
`define COMPAT_MAJOR    16'd8
`define COMPAT_MINOR    16'd2

`define LED_SRC_RESET   8'b0001_1110   // HW drives LEDs 4..1 out of reset

`define RB_WORD_TIME_HI 10
`define RB_WORD_TIME_LO 11
`define RB_WORD_COMPAT  12
`define RB_WORD_STATUS  13
`define RB_WORD_PPS_HI  14
`define RB_WORD_PPS_LO  15

`endif

// ==== hdl/settings_pkg.sv ====
// Settings bus types
//   address and data words of a settings write
//   control byte and LED vector types
//   register bank layout of the misc control block
`include "core_cfg.svh"

package settings_pkg;

   ////////////////////////////////////////////////////////////
   // Bus words
   ////////////////////////////////////////////////////////////

   typedef logic [`SET_ADDR_W-1:0] set_addr_t;
   typedef logic [`SET_DATA_W-1:0] set_data_t;

   ////////////////////////////////////////////////////////////
   // Register fields
   ////////////////////////////////////////////////////////////

   typedef logic [`CTRL_W-1:0] ctrl_byte_t;   // One misc control register
   typedef logic [`LED_W-1:0]  led_vec_t;     // LED pattern or source mask

   // Misc register bank
   typedef struct packed {
      ctrl_byte_t clk_ctrl;    // {clock_ready, clk_en[1:0], clk_sel[1:0]}
      ctrl_byte_t ser_ctrl;    // {enable, prbsen, loopen, rx_en}
      ctrl_byte_t adc_ctrl;    // {oe_a, on_a, oe_b, on_b}
      led_vec_t   led_sw;
      logic       phy_reset;   // Active high here, pin is inverted
      led_vec_t   led_src;     // 1 = HW, 0 = SW
   } misc_regs_t;

endpackage

// ==== hdl/timing_pkg.sv ====
// VITA time and readback port types
//   time value in ticks
//   readback word number and word
//   high/low split of a time value
`include "core_cfg.svh"

package timing_pkg;

   typedef logic [`VITA_TIME_W-1:0] vita_time_t;

   ////////////////////////////////////////////////////////////
   // Readback port
   ////////////////////////////////////////////////////////////

   typedef logic [`RB_ADDR_W-1:0] rb_addr_t;
   typedef logic [`RB_WORD_W-1:0] rb_word_t;

   // Time as two readback words
   typedef struct packed {
      rb_word_t hi;
      rb_word_t lo;
   } vita_halves_t;

endpackage

// ==== hdl/misc_ctrl_regs.sv ====
// Misc control register bank on the settings bus
//   clock-gen, SERDES and ADC control bytes
//   software LED pattern and LED source mask
//   PHY reset, driven active low on the pin
`timescale 1ns/1ps
`include "core_cfg.svh"

module misc_ctrl_regs
   import settings_pkg::*;
(
   input  logic      dsp_clk,
   input  logic      por_rst,
   input  logic      set_stb_i,
   input  set_addr_t set_addr_i,
   input  set_data_t set_data_i,
   output logic      clock_ready_o,
   output logic [1:0] clk_en_o,
   output logic [1:0] clk_sel_o,
   output logic      ser_enable_o,
   output logic      ser_prbsen_o,
   output logic      ser_loopen_o,
   output logic      ser_rx_en_o,
   output logic      adc_oe_a_o,
   output logic      adc_on_a_o,
   output logic      adc_oe_b_o,
   output logic      adc_on_b_o,
   output logic      phy_reset_n_o,
   output led_vec_t  led_sw_o,
   output led_vec_t  led_src_o
);

   misc_regs_t regs;

   ////////////////////////////////////////////////////////////
   // Register writes
   ////////////////////////////////////////////////////////////

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         regs.clk_ctrl  <= '0;
         regs.ser_ctrl  <= '0;
         regs.adc_ctrl  <= '0;
         regs.led_sw    <= '0;
         regs.phy_reset <= 1'b0;          // PHY out of reset
         regs.led_src   <= `LED_SRC_RESET;
      end else if (set_stb_i) begin
         case (set_addr_i)
            set_addr_t'(`SR_MISC + `MISC_OFS_CLK):
               regs.clk_ctrl <= set_data_i[`CTRL_W-1:0];
            set_addr_t'(`SR_MISC + `MISC_OFS_SER):
               regs.ser_ctrl <= set_data_i[`CTRL_W-1:0];
            set_addr_t'(`SR_MISC + `MISC_OFS_ADC):
               regs.adc_ctrl <= set_data_i[`CTRL_W-1:0];
            set_addr_t'(`SR_MISC + `MISC_OFS_LED_SW):
               regs.led_sw <= set_data_i[`LED_W-1:0];
            set_addr_t'(`SR_MISC + `MISC_OFS_PHY):
               regs.phy_reset <= set_data_i[0];
            set_addr_t'(`SR_MISC + `MISC_OFS_LED_SRC):
               regs.led_src <= set_data_i[`LED_W-1:0];
            default: ;                    // Not ours
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // Pin-level split
   ////////////////////////////////////////////////////////////

   assign {clock_ready_o, clk_en_o, clk_sel_o} = regs.clk_ctrl[`CLK_CTRL_BITS-1:0];
   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} =
      regs.ser_ctrl[`SER_CTRL_BITS-1:0];
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} =
      regs.adc_ctrl[`ADC_CTRL_BITS-1:0];

   assign phy_reset_n_o = ~regs.phy_reset;
   assign led_sw_o      = regs.led_sw;
   assign led_src_o     = regs.led_src;

   // Master must present a clean address with every strobe
   a_set_addr_known: assert property (
      @(posedge dsp_clk) disable iff (por_rst)
      set_stb_i |-> !$isunknown(set_addr_i));

endmodule

// ==== hdl/vita_timekeeper.sv ====
// VITA 64-bit timekeeper
//   free-running tick counter, loaded by a two-word settings write
//   PPS synchronizer and rising-edge detect
//   time latch and sync flag at each PPS edge
`timescale 1ns/1ps
`include "core_cfg.svh"

module vita_timekeeper
   import settings_pkg::*;
   import timing_pkg::*;
(
   input  logic       dsp_clk,
   input  logic       por_rst,
   input  logic       set_stb_i,
   input  set_addr_t  set_addr_i,
   input  set_data_t  set_data_i,
   input  logic       pps_i,
   output vita_time_t vita_time_o,
   output vita_time_t vita_time_pps_o,
   output logic       pps_int_o,
   output logic       good_sync_o
);

   vita_time_t time_cnt;
   vita_time_t time_pps;
   set_data_t  hi_hold;      // High word waits here for the low word
   logic       load_hi;
   logic       load_lo;
   logic       pps_sync;
   logic       pps_d;
   logic       pps_edge;
   logic       pps_int;
   logic       good_sync;

   assign load_hi = set_stb_i && (set_addr_i == set_addr_t'(`SR_TIME64 + `TIME_OFS_HI));
   assign load_lo = set_stb_i && (set_addr_i == set_addr_t'(`SR_TIME64 + `TIME_OFS_LO));

   ////////////////////////////////////////////////////////////
   // Time counter
   ////////////////////////////////////////////////////////////

   always_ff @(posedge dsp_clk) begin
      if (load_hi)
         hi_hold <= set_data_i;
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst)
         time_cnt <= '0;
      else if (load_lo)
         time_cnt <= {hi_hold, set_data_i};   // Low word write commits both halves
      else
         time_cnt <= time_cnt + 64'd1;
   end

   ////////////////////////////////////////////////////////////
   // PPS edge and latch
   ////////////////////////////////////////////////////////////

   assign pps_edge = pps_sync & ~pps_d;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_sync  <= 1'b0;
         pps_d     <= 1'b0;
         pps_int   <= 1'b0;
         time_pps  <= '0;
         good_sync <= 1'b0;
      end else begin
         pps_sync <= pps_i;                  // pps_i is asynchronous
         pps_d    <= pps_sync;
         pps_int  <= pps_edge;
         if (pps_edge)
            time_pps <= time_cnt;
         if (load_lo)
            good_sync <= 1'b0;               // New time, wait for next PPS
         else if (pps_edge)
            good_sync <= 1'b1;
      end
   end

   assign vita_time_o     = time_cnt;
   assign vita_time_pps_o = time_pps;
   assign pps_int_o       = pps_int;
   assign good_sync_o     = good_sync;

   a_time_step: assert property (
      @(posedge dsp_clk) disable iff (por_rst)
      !load_lo |=> time_cnt == $past(time_cnt) + 64'd1);

   a_pps_int_single: assert property (
      @(posedge dsp_clk) disable iff (por_rst)
      pps_int_o |=> !pps_int_o);

endmodule

// ==== hdl/status_combiner.sv ====
// Status combiner
//   hardware LED pattern merged with the SW pattern per source bit
//   registered 16-word readback mux with time, compat and status words
`timescale 1ns/1ps
`include "core_cfg.svh"

module status_combiner
   import settings_pkg::*;
   import timing_pkg::*;
(
   input  logic       dsp_clk,
   input  logic       por_rst,
   input  led_vec_t   led_sw_i,
   input  led_vec_t   led_src_i,
   input  logic       run_rx_i,
   input  logic       run_tx_i,
   input  logic       clk_status_i,
   input  logic       serdes_link_up_i,
   input  logic       good_sync_i,
   input  logic       button_i,
   input  vita_time_t vita_time_i,
   input  vita_time_t vita_time_pps_i,
   input  rb_addr_t   rb_addr_i,
   output led_vec_t   leds_o,
   output rb_word_t   rb_data_o
);

   led_vec_t     led_hw;
   vita_halves_t now_split;
   vita_halves_t pps_split;
   rb_word_t     rb_next;

   ////////////////////////////////////////////////////////////
   // LEDs
   ////////////////////////////////////////////////////////////

   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i,
                    serdes_link_up_i & good_sync_i, 1'b0};

   always_ff @(posedge dsp_clk) begin
      if (por_rst)
         leds_o <= led_hw & `LED_SRC_RESET;
      else
         leds_o <= (led_src_i & led_hw) | (~led_src_i & led_sw_i);
   end

   ////////////////////////////////////////////////////////////
   // Readback
   ////////////////////////////////////////////////////////////

   assign now_split = vita_time_i;
   assign pps_split = vita_time_pps_i;

   always_comb begin
      case (rb_addr_i)
         rb_addr_t'(`RB_WORD_TIME_HI): rb_next = now_split.hi;
         rb_addr_t'(`RB_WORD_TIME_LO): rb_next = now_split.lo;
         rb_addr_t'(`RB_WORD_COMPAT):  rb_next = {`COMPAT_MAJOR, `COMPAT_MINOR};
         rb_addr_t'(`RB_WORD_STATUS):
            rb_next = {18'b0, button_i, 1'b0, clk_status_i, serdes_link_up_i, 10'b0};
         rb_addr_t'(`RB_WORD_PPS_HI):  rb_next = pps_split.hi;
         rb_addr_t'(`RB_WORD_PPS_LO):  rb_next = pps_split.lo;
         default:                      rb_next = '0;   // Words 0..9 unused
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst)
         rb_data_o <= '0;
      else
         rb_data_o <= rb_next;
   end

   a_rb_addr_known: assert property (
      @(posedge dsp_clk) disable iff (por_rst)
      !$isunknown(rb_addr_i));

endmodule

// ==== hdl/radio_ctrl_core.sv ====
// Radio control core, DSP clock domain
//   misc control registers and VITA timekeeper on the settings bus
//   status combiner for LEDs and readback
`timescale 1ns/1ps

module radio_ctrl_core
   import settings_pkg::*;
   import timing_pkg::*;
(
   input  logic      dsp_clk,
   input  logic      por_rst,
   // Settings bus
   input  logic      set_stb_i,
   input  set_addr_t set_addr_i,
   input  set_data_t set_data_i,
   // Timing and status inputs
   input  logic      pps_i,
   input  logic      run_rx_i,
   input  logic      run_tx_i,
   input  logic      clk_status_i,
   input  logic      serdes_link_up_i,
   input  logic      button_i,
   input  rb_addr_t  rb_addr_i,
   // Control pins
   output logic      clock_ready_o,
   output logic [1:0] clk_en_o,
   output logic [1:0] clk_sel_o,
   output logic      ser_enable_o,
   output logic      ser_prbsen_o,
   output logic      ser_loopen_o,
   output logic      ser_rx_en_o,
   output logic      adc_oe_a_o,
   output logic      adc_on_a_o,
   output logic      adc_oe_b_o,
   output logic      adc_on_b_o,
   output logic      phy_reset_n_o,
   output logic      pps_int_o,
   output led_vec_t  leds_o,
   output rb_word_t  rb_data_o
);

   led_vec_t   led_sw;
   led_vec_t   led_src;
   vita_time_t vita_time;
   vita_time_t vita_time_pps;
   logic       good_sync;

   misc_ctrl_regs u_misc_regs (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .clock_ready_o(clock_ready_o), .clk_en_o(clk_en_o), .clk_sel_o(clk_sel_o),
      .ser_enable_o(ser_enable_o), .ser_prbsen_o(ser_prbsen_o),
      .ser_loopen_o(ser_loopen_o), .ser_rx_en_o(ser_rx_en_o),
      .adc_oe_a_o(adc_oe_a_o), .adc_on_a_o(adc_on_a_o),
      .adc_oe_b_o(adc_oe_b_o), .adc_on_b_o(adc_on_b_o),
      .phy_reset_n_o(phy_reset_n_o), .led_sw_o(led_sw), .led_src_o(led_src)
   );

   vita_timekeeper u_timekeeper (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .pps_i(pps_i), .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps),
      .pps_int_o(pps_int_o), .good_sync_o(good_sync)
   );

   status_combiner u_status (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .led_sw_i(led_sw), .led_src_i(led_src),
      .run_rx_i(run_rx_i), .run_tx_i(run_tx_i), .clk_status_i(clk_status_i),
      .serdes_link_up_i(serdes_link_up_i), .good_sync_i(good_sync), .button_i(button_i),
      .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps),
      .rb_addr_i(rb_addr_i), .leds_o(leds_o), .rb_data_o(rb_data_o)
   );

endmodule

// ==== tests/radio_ctrl_core_tb.sv ====
// Testbench for the radio control core
//   settings-bus writes, misc pins, LED mux, readback words
//   time load and count, PPS latch and sync flag
//   LFSR data source, watchdog and summary
`timescale 1ns/1ps
`include "core_cfg.svh"

module radio_ctrl_core_tb
   import settings_pkg::*;
   import timing_pkg::*;
;
   localparam int CLK_PERIOD = 10;
   localparam int RESET_CYCLES = 16;
   localparam int MISC_N = 12;
   localparam int LED_N = 5;
   localparam int RB_N = 7;
   localparam int TIME_N = 5;
   localparam int TOTAL_ROWS = 2 + MISC_N + LED_N + RB_N + TIME_N;   // Reset and PPS add one each
   localparam int WATCHDOG_CYCLES = TOTAL_ROWS * 20 + RESET_CYCLES;

   localparam set_addr_t A_CLK     = set_addr_t'(`SR_MISC + `MISC_OFS_CLK);
   localparam set_addr_t A_SER     = set_addr_t'(`SR_MISC + `MISC_OFS_SER);
   localparam set_addr_t A_ADC     = set_addr_t'(`SR_MISC + `MISC_OFS_ADC);
   localparam set_addr_t A_LED_SW  = set_addr_t'(`SR_MISC + `MISC_OFS_LED_SW);
   localparam set_addr_t A_PHY     = set_addr_t'(`SR_MISC + `MISC_OFS_PHY);
   localparam set_addr_t A_LED_SRC = set_addr_t'(`SR_MISC + `MISC_OFS_LED_SRC);
   localparam set_addr_t A_TIME_HI = set_addr_t'(`SR_TIME64 + `TIME_OFS_HI);
   localparam set_addr_t A_TIME_LO = set_addr_t'(`SR_TIME64 + `TIME_OFS_LO);

   typedef struct packed {
      set_addr_t addr;
      logic      used;        // Address belongs to a misc register
   } misc_row_t;
   typedef struct packed {
      led_vec_t   sw;
      led_vec_t   src;
      logic [3:0] hw_in;      // {run_tx, run_rx, clk_status, link_up}
      led_vec_t   leds;
   } led_row_t;
   typedef struct packed {
      rb_addr_t   addr;
      logic [2:0] st_in;      // {button, clk_status, link_up}
      rb_word_t   word;
   } rb_row_t;

   logic dsp_clk, por_rst, set_stb_i, pps_i;
   logic run_rx_i, run_tx_i, clk_status_i, serdes_link_up_i, button_i;
   set_addr_t set_addr_i;
   set_data_t set_data_i;
   rb_addr_t  rb_addr_i;
   logic clock_ready_o, ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o;
   logic adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o, phy_reset_n_o, pps_int_o;
   logic [1:0] clk_en_o, clk_sel_o;
   led_vec_t leds_o;
   rb_word_t rb_data_o;

   misc_row_t misc_tbl [MISC_N] = '{
      '{A_CLK, 1'b1}, '{A_SER, 1'b1}, '{A_ADC, 1'b1}, '{A_LED_SW, 1'b1},
      '{A_PHY, 1'b1}, '{A_LED_SRC, 1'b1}, '{8'd5, 1'b0}, '{8'd7, 1'b0},
      '{8'd9, 1'b0}, '{8'h80, 1'b0}, '{8'hFF, 1'b0}, '{A_PHY, 1'b1}};
   led_row_t led_tbl [LED_N] = '{             // good_sync still low here
      '{8'hA5, 8'h00, 4'b1111, 8'hA5}, '{8'h00, 8'hFF, 4'b1111, 8'h1C},
      '{8'hFF, 8'h1E, 4'b1010, 8'hF5}, '{8'h3C, 8'h0F, 4'b0100, 8'h38},
      '{8'h81, 8'h18, 4'b1001, 8'h91}};
   rb_row_t rb_tbl [RB_N] = '{
      '{4'd12, 3'b000, 32'h0008_0002}, '{4'd13, 3'b100, 32'h0000_2000},
      '{4'd13, 3'b011, 32'h0000_0C00}, '{4'd13, 3'b111, 32'h0000_2C00},
      '{4'd0, 3'b111, 32'h0}, '{4'd5, 3'b000, 32'h0}, '{4'd9, 3'b111, 32'h0}};
   int delay_tbl [TIME_N] = '{0, 1, 3, 7, 20};

   logic [7:0]  shadow [0:7];                 // Expected misc register contents
   logic [31:0] lfsr_state = 32'd23;
   int check_count = 0;
   int error_count = 0;
   int start_checks = 0;
   int start_errors = 0;

   radio_ctrl_core dut (.*);

   initial begin
      dsp_clk = 1'b0;
      forever #(CLK_PERIOD / 2) dsp_clk = ~dsp_clk;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Simulation FAILED");
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   // x^32 + x^22 + x^2 + x + 1, one step per bit
   function automatic logic [31:0] random_word();
      logic [31:0] word;
      logic        fb;
      word = '0;
      for (int b = 0; b < 32; b++) begin
         fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         word = {word[30:0], fb};
      end
      return word;
   endfunction

   function automatic led_vec_t hw_pattern(input logic tx, input logic rx, input logic clk_ok,
                                           input logic synced_link);
      return {3'b000, tx, rx, clk_ok, synced_link, 1'b0};
   endfunction

   // Source bit set picks the hardware bit, clear picks the software bit
   function automatic led_vec_t expected_leds(input led_vec_t src, input led_vec_t hw,
                                              input led_vec_t sw);
      led_vec_t leds;
      for (int b = 0; b < `LED_W; b++) begin
         if (src[b])
            leds[b] = hw[b];
         else
            leds[b] = sw[b];
      end
      return leds;
   endfunction

   task automatic tick();
      @(negedge dsp_clk);
   endtask

   task automatic write_setting(input set_addr_t addr, input set_data_t data);
      set_stb_i  = 1'b1;
      set_addr_i = addr;
      set_data_i = data;
      @(negedge dsp_clk);
      set_stb_i = 1'b0;
   endtask

   task automatic check_value(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
      check_count++;
      assert (got === exp) else begin
         $display("Error at %0t ns: %s got 0x%0h, expected 0x%0h", $time, what, got, exp);
         error_count++;
      end
   endtask

   task automatic check_misc_pins(input string what);
      logic [13:0] got;
      logic [13:0] exp;
      got = {clock_ready_o, clk_en_o, clk_sel_o, ser_enable_o, ser_prbsen_o, ser_loopen_o,
             ser_rx_en_o, adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o, phy_reset_n_o};
      exp = {shadow[0][4:0], shadow[1][3:0], shadow[2][3:0], ~shadow[4][0]};
      check_value(what, 64'(got), 64'(exp));
   endtask

   task automatic end_test(input string name);
      $display("Test %-10s %0d checks, %0d errors", name,
               check_count - start_checks, error_count - start_errors);
      start_checks = check_count;
      start_errors = error_count;
   endtask

   ////////////////////////////////////////////////////////////
   // Tests
   ////////////////////////////////////////////////////////////

   task automatic misc_test();
      set_data_t data;
      led_vec_t  hw;
      for (int i = 0; i < MISC_N; i++) begin
         data = random_word();
         write_setting(misc_tbl[i].addr, data);
         if (misc_tbl[i].used)
            shadow[misc_tbl[i].addr[2:0]] = data[7:0];
         check_misc_pins($sformatf("misc pins after write %0d", i));
         tick();                                   // LEDs lag one more cycle
         hw = hw_pattern(run_tx_i, run_rx_i, clk_status_i, 1'b0);
         check_value($sformatf("leds after write %0d", i), 64'(leds_o),
                     64'(expected_leds(shadow[6], hw, shadow[3])));
      end
      end_test("misc");
   endtask

   task automatic led_test();
      for (int i = 0; i < LED_N; i++) begin
         write_setting(A_LED_SW, 32'(led_tbl[i].sw));
         write_setting(A_LED_SRC, 32'(led_tbl[i].src));
         {run_tx_i, run_rx_i, clk_status_i, serdes_link_up_i} = led_tbl[i].hw_in;
         tick();
         check_value($sformatf("leds row %0d", i), 64'(leds_o), 64'(led_tbl[i].leds));
      end
      end_test("led_mux");
   endtask

   task automatic readback_test();
      for (int i = 0; i < RB_N; i++) begin
         rb_addr_i = rb_tbl[i].addr;
         {button_i, clk_status_i, serdes_link_up_i} = rb_tbl[i].st_in;
         tick();
         check_value($sformatf("readback row %0d", i), 64'(rb_data_o), 64'(rb_tbl[i].word));
      end
      end_test("readback");
   endtask

   task automatic time_test();
      set_data_t hi;
      set_data_t lo;
      for (int i = 0; i < TIME_N; i++) begin
         hi = random_word();
         lo = random_word() & 32'h7FFF_FFFF;     // No carry into the high word
         rb_addr_i = rb_addr_t'(`RB_WORD_TIME_LO);
         write_setting(A_TIME_HI, hi);
         write_setting(A_TIME_LO, lo);
         repeat (delay_tbl[i] + 2) tick();       // Counter plus readback register
         check_value($sformatf("time low, delay %0d", delay_tbl[i]), 64'(rb_data_o),
                     64'(lo + 32'(delay_tbl[i]) + 32'd1));
         rb_addr_i = rb_addr_t'(`RB_WORD_TIME_HI);
         tick();
         check_value("time high", 64'(rb_data_o), 64'(hi));
      end
      end_test("time");
   endtask

   task automatic pps_test();
      set_data_t hi;
      set_data_t lo;
      set_data_t first;
      int        pulses;
      serdes_link_up_i = 1'b1;
      write_setting(A_LED_SRC, 32'h0000_0002);  // Only the sync LED from hardware
      hi = random_word();
      lo = random_word() & 32'h7FFF_FFFF;
      write_setting(A_TIME_HI, hi);
      write_setting(A_TIME_LO, lo);             // Counter reads lo here
      repeat (2) tick();
      check_value("sync LED before PPS", 64'(leds_o[1]), 64'd0);
      repeat (2) tick();
      pps_i = 1'b1;
      first = lo + 32'd4;
      pulses = 0;
      repeat (8) begin
         tick();
         if (pps_int_o)
            pulses++;
      end
      pps_i = 1'b0;
      check_value("pps_int pulses", 64'(pulses), 64'd1);
      check_value("sync LED after PPS", 64'(leds_o[1]), 64'd1);
      rb_addr_i = rb_addr_t'(`RB_WORD_PPS_HI);
      tick();
      check_value("PPS time high", 64'(rb_data_o), 64'(hi));
      rb_addr_i = rb_addr_t'(`RB_WORD_PPS_LO);
      tick();
      check_count++;
      assert ((rb_data_o >= first) && (rb_data_o <= first + 32'd3)) else begin
         $display("Error at %0t ns: PPS time 0x%0h outside 0x%0h to 0x%0h",
                  $time, rb_data_o, first, first + 32'd3);
         error_count++;
      end
      write_setting(A_TIME_HI, random_word());
      write_setting(A_TIME_LO, random_word());
      tick();
      check_value("sync LED after time load", 64'(leds_o[1]), 64'd0);
      end_test("pps");
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////

   initial begin
      por_rst = 1'b1;
      set_stb_i = 1'b0;
      set_addr_i = '0;
      set_data_i = '0;
      pps_i = 1'b0;
      run_rx_i = 1'b0;
      run_tx_i = 1'b1;
      clk_status_i = 1'b1;
      serdes_link_up_i = 1'b1;
      button_i = 1'b0;
      rb_addr_i = '0;
      for (int i = 0; i < 8; i++)
         shadow[i] = 8'h00;
      shadow[6] = 8'b0001_1110;                 // LED source comes up as 4..1 hardware

      repeat (RESET_CYCLES) tick();
      check_misc_pins("pins in reset");
      check_value("rb_data in reset", 64'(rb_data_o), 64'd0);
      check_value("leds in reset", 64'(leds_o),
                  64'(hw_pattern(run_tx_i, run_rx_i, clk_status_i, 1'b0) & 8'b0001_1110));
      por_rst = 1'b0;
      end_test("reset");

      misc_test();
      led_test();
      readback_test();
      time_test();
      pps_test();

      $display("Summary: 6 tests, %0d checks, %0d errors", check_count, error_count);
      if (error_count == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

// ==== all.f ====
+incdir+hdl
hdl/settings_pkg.sv
hdl/timing_pkg.sv
hdl/misc_ctrl_regs.sv
hdl/vita_timekeeper.sv
hdl/status_combiner.sv
hdl/radio_ctrl_core.sv
tests/radio_ctrl_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the radio control core testbench with Verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -f all.f --top-module radio_ctrl_core_tb -o radio_ctrl_sim \
   && ./obj_dir/radio_ctrl_sim > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "Build or run error"; exit 1; }
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1 || exit 0
